/* hdl/muldiv_settings.svh */
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result width of the unit
`define MULDIV_XLEN 32

// both iterative units retire one bit per cycle
`define MULDIV_ITERS `MULDIV_XLEN

`endif

/* hdl/muldiv_pkg.sv */
package muldiv_pkg;

    // encoding follows the RISC-V funct3 field of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    // shared by the multiplier and the divider core
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } iter_state_e;

endpackage

/* hdl/muldiv_req_if.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

// request bus from the issue stage to both arithmetic units and the result stage
interface muldiv_req_if;
    import muldiv_pkg::*;

    logic                    valid; // one-cycle pulse per issued operation
    muldiv_op_e              op;
    logic [`MULDIV_XLEN-1:0] a;     // rs1 value
    logic [`MULDIV_XLEN-1:0] b;     // rs2 value

    modport issue (
        output valid,
        output op,
        output a,
        output b
    );

    modport unit (
        input valid,
        input op,
        input a,
        input b
    );

endinterface

/* hdl/muldiv_issue.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module muldiv_issue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [2:0]              funct3,
    input  logic [`MULDIV_XLEN-1:0] rs1,
    input  logic [`MULDIV_XLEN-1:0] rs2,
    input  logic                    busy,
    muldiv_req_if.issue             req
);
    import muldiv_pkg::*;

    logic accept;

    always_comb begin
        accept = start && !busy; // a start during a running operation is dropped
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept; // high for the single cycle after the accepting edge
        end
    end

    // operands and opcode stay put until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op <= muldiv_op_e'(funct3);
            req.a  <= rs1;
            req.b  <= rs2;
        end
    end

    // busy comes back from the result stage, so this checks the loop through both stages
    a_no_issue_while_busy : assert property (
        @(posedge clk) disable iff (reset)
        req.valid |-> !$past(busy)
    );

endmodule

/* hdl/shift_add_multiplier.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module shift_add_multiplier (
    input  logic                    clk,
    input  logic                    reset,
    muldiv_req_if.unit              req,
    output logic                    finished,
    output logic [`MULDIV_XLEN-1:0] product_hi,
    output logic [`MULDIV_XLEN-1:0] product_lo
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(`MULDIV_ITERS);

    iter_state_e               state;
    logic [CNT_W-1:0]          count;
    logic [`MULDIV_XLEN-1:0]   mcand;    // multiplicand magnitude
    logic [`MULDIV_XLEN-1:0]   acc_hi;   // running partial sum
    logic [`MULDIV_XLEN-1:0]   acc_lo;   // multiplier bits shift out as product bits shift in
    logic                      negate;
    logic                      accept;
    logic                      a_neg;
    logic                      b_neg;
    logic [`MULDIV_XLEN-1:0]   a_mag;
    logic [`MULDIV_XLEN-1:0]   b_mag;
    logic [`MULDIV_XLEN:0]     partial;  // one extra bit for the carry
    logic [2*`MULDIV_XLEN-1:0] product;

    always_comb begin
        accept  = req.valid && (req.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU});
        a_neg   = req.a[`MULDIV_XLEN-1] && (req.op == OP_MULH || req.op == OP_MULHSU);
        b_neg   = req.b[`MULDIV_XLEN-1] && (req.op == OP_MULH); // rs2 is signed only for MULH
        a_mag   = a_neg ? -req.a : req.a;
        b_mag   = b_neg ? -req.b : req.b;
        partial = acc_lo[0] ? {1'b0, acc_hi} + {1'b0, mcand} : {1'b0, acc_hi};
    end

    always_comb begin
        product    = negate ? -{acc_hi, acc_lo} : {acc_hi, acc_lo};
        product_hi = product[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
        product_lo = product[`MULDIV_XLEN-1:0];
        finished   = (state == ST_DONE);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_RUN;
                        count <= '0;
                    end
                end
                ST_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`MULDIV_ITERS - 1)) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE; // ST_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && accept) begin
            mcand  <= b_mag;
            acc_hi <= '0;
            acc_lo <= a_mag;
            negate <= a_neg ^ b_neg;
        end else if (state == ST_RUN) begin
            {acc_hi, acc_lo} <= {partial, acc_lo[`MULDIV_XLEN-1:1]}; // add then shift right
        end
    end

    a_finished_pulse : assert property (
        @(posedge clk) disable iff (reset)
        finished |=> !finished
    );

endmodule

/* hdl/restoring_divider.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module restoring_divider (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [`MULDIV_XLEN-1:0] dividend,
    input  logic [`MULDIV_XLEN-1:0] divisor,
    output logic [`MULDIV_XLEN-1:0] quotient,
    output logic [`MULDIV_XLEN-1:0] remainder,
    output logic                    busy_core,
    output logic                    finished
);
    import muldiv_pkg::*;

    localparam int CNT_W = $clog2(`MULDIV_ITERS + 1);

    iter_state_e             state;
    logic [CNT_W-1:0]        count;
    logic [`MULDIV_XLEN-1:0] rem_reg;     // partial remainder
    logic [`MULDIV_XLEN-1:0] quo_reg;     // dividend bits leave at the top, quotient bits enter below
    logic [`MULDIV_XLEN-1:0] divisor_reg;
    logic [`MULDIV_XLEN-1:0] shifted;
    logic [`MULDIV_XLEN-1:0] next_rem;
    logic [`MULDIV_XLEN:0]   diff;        // top bit is the borrow
    logic                    q_bit;

    always_comb begin
        shifted  = {rem_reg[`MULDIV_XLEN-2:0], quo_reg[`MULDIV_XLEN-1]};
        diff     = {1'b0, shifted} - {1'b0, divisor_reg};
        // a set top bit means the true shifted value exceeds any divisor
        q_bit    = rem_reg[`MULDIV_XLEN-1] || !diff[`MULDIV_XLEN];
        next_rem = q_bit ? diff[`MULDIV_XLEN-1:0] : shifted; // restore on a borrow
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                        count <= '0;
                    end
                end
                ST_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`MULDIV_ITERS - 1)) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            rem_reg     <= '0;
            quo_reg     <= dividend;
            divisor_reg <= divisor;
        end else if (state == ST_RUN) begin
            rem_reg <= next_rem;
            quo_reg <= {quo_reg[`MULDIV_XLEN-2:0], q_bit};
        end
    end

    assign quotient  = quo_reg;
    assign remainder = rem_reg;
    assign busy_core = (state == ST_RUN);
    assign finished  = (state == ST_DONE);

    a_count_in_range : assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_RUN) |-> (count <= CNT_W'(`MULDIV_ITERS - 1))
    );

endmodule

/* hdl/div_sign_wrap.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module div_sign_wrap (
    input  logic                    clk,
    input  logic                    reset,
    muldiv_req_if.unit              req,
    output logic                    finished,
    output logic [`MULDIV_XLEN-1:0] quotient,
    output logic [`MULDIV_XLEN-1:0] remainder
);
    import muldiv_pkg::*;

    logic                    is_signed;
    logic                    accept;
    logic                    core_start;
    logic                    core_busy;
    logic [`MULDIV_XLEN-1:0] dividend_mag;
    logic [`MULDIV_XLEN-1:0] divisor_mag;
    logic [`MULDIV_XLEN-1:0] quo_mag;
    logic [`MULDIV_XLEN-1:0] rem_mag;
    logic [`MULDIV_XLEN-1:0] dividend_q; // returned as remainder on a zero divisor
    logic                    neg_quo;
    logic                    neg_rem;
    logic                    div_zero;

    always_comb begin
        is_signed    = (req.op == OP_DIV) || (req.op == OP_REM);
        accept       = req.valid && (req.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});
        core_start   = accept && !core_busy; // the core never sees a second start mid-run
        dividend_mag = (is_signed && req.a[`MULDIV_XLEN-1]) ? -req.a : req.a;
        divisor_mag  = (is_signed && req.b[`MULDIV_XLEN-1]) ? -req.b : req.b;
    end

    always_ff @(posedge clk) begin
        if (core_start) begin
            neg_quo    <= is_signed && (req.a[`MULDIV_XLEN-1] ^ req.b[`MULDIV_XLEN-1]);
            neg_rem    <= is_signed && req.a[`MULDIV_XLEN-1]; // remainder follows the dividend
            div_zero   <= (req.b == '0);
            dividend_q <= req.a;
        end
    end

    // zero divisors still run the core so latency does not depend on the operands
    restoring_divider i_core (
        .clk       (clk),
        .reset     (reset),
        .start     (core_start),
        .dividend  (dividend_mag),
        .divisor   (divisor_mag),
        .quotient  (quo_mag),
        .remainder (rem_mag),
        .busy_core (core_busy),
        .finished  (finished)
    );

    // the most negative value over minus one needs nothing extra here
    always_comb begin
        if (div_zero) begin
            quotient  = '1;
            remainder = dividend_q;
        end else begin
            quotient  = neg_quo ? -quo_mag : quo_mag;
            remainder = neg_rem ? -rem_mag : rem_mag;
        end
    end

endmodule

/* hdl/muldiv_result.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module muldiv_result (
    input  logic                    clk,
    input  logic                    reset,
    muldiv_req_if.unit              req,
    input  logic                    mul_finished,
    input  logic [`MULDIV_XLEN-1:0] product_hi,
    input  logic [`MULDIV_XLEN-1:0] product_lo,
    input  logic                    div_finished,
    input  logic [`MULDIV_XLEN-1:0] quotient,
    input  logic [`MULDIV_XLEN-1:0] remainder,
    output logic                    busy,
    output logic                    done,
    output logic [`MULDIV_XLEN-1:0] result
);
    import muldiv_pkg::*;

    muldiv_op_e              op_q;     // op of the request in flight
    logic                    busy_q;
    logic                    unit_finished;
    logic [`MULDIV_XLEN-1:0] selected;

    always_comb begin
        unit_finished = mul_finished || div_finished;
        // valid covers the cycle between the accepting edge and the unit load
        busy          = busy_q || req.valid;
        case (op_q)
            OP_MUL:                       selected = product_lo;
            OP_MULH, OP_MULHSU, OP_MULHU: selected = product_hi;
            OP_DIV, OP_DIVU:              selected = quotient;
            default:                      selected = remainder; // REM and REMU
        endcase
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            op_q <= req.op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= unit_finished; // one cycle, since each unit's finished is one cycle
            if (unit_finished) begin
                busy_q <= 1'b0;
                result <= selected; // held until the next completion
            end else if (req.valid) begin
                busy_q <= 1'b1;
            end
        end
    end

    a_one_unit_finishes : assert property (
        @(posedge clk) disable iff (reset)
        !(mul_finished && div_finished)
    );

endmodule

/* hdl/muldiv_top.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module muldiv_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [2:0]              funct3,
    input  logic [`MULDIV_XLEN-1:0] rs1,
    input  logic [`MULDIV_XLEN-1:0] rs2,
    output logic                    busy,
    output logic                    done,
    output logic [`MULDIV_XLEN-1:0] result
);

    logic                    mul_finished;
    logic [`MULDIV_XLEN-1:0] product_hi;
    logic [`MULDIV_XLEN-1:0] product_lo;
    logic                    div_finished;
    logic [`MULDIV_XLEN-1:0] quotient;
    logic [`MULDIV_XLEN-1:0] remainder;

    muldiv_req_if req_bus (); // fans out to both units and the result stage

    muldiv_issue i_issue (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .funct3 (funct3),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .req    (req_bus.issue)
    );

    shift_add_multiplier i_mul (
        .clk        (clk),
        .reset      (reset),
        .req        (req_bus.unit),
        .finished   (mul_finished),
        .product_hi (product_hi),
        .product_lo (product_lo)
    );

    div_sign_wrap i_div (
        .clk       (clk),
        .reset     (reset),
        .req       (req_bus.unit),
        .finished  (div_finished),
        .quotient  (quotient),
        .remainder (remainder)
    );

    muldiv_result i_result (
        .clk          (clk),
        .reset        (reset),
        .req          (req_bus.unit),
        .mul_finished (mul_finished),
        .product_hi   (product_hi),
        .product_lo   (product_lo),
        .div_finished (div_finished),
        .quotient     (quotient),
        .remainder    (remainder),
        .busy         (busy),
        .done         (done),
        .result       (result)
    );

endmodule

/* sim/muldiv_tb.sv */
`timescale 1ns/1ns
`include "muldiv_settings.svh"

module muldiv_tb;
    import muldiv_pkg::*;

    localparam int XLEN          = `MULDIV_XLEN;
    localparam int CLK_PERIOD    = 8;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_ROWS      = 27;
    localparam int NUM_RANDOM    = 200;
    localparam int LATENCY_EDGES = 35; // counted from the edge that samples start, inclusive
    localparam int EDGE_LIMIT    = 40;
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS + NUM_RANDOM + 2) * 40 * CLK_PERIOD;

    logic            clk;
    logic            reset;
    logic            start;
    logic [2:0]      funct3;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] result;

    string           row_name[$];
    muldiv_op_e      row_op[$];
    logic [XLEN-1:0] row_a[$];
    logic [XLEN-1:0] row_b[$];
    logic [XLEN-1:0] row_exp[$];

    muldiv_top i_muldiv_top (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .funct3 (funct3),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_result(input string name, input muldiv_op_e op,
                                  input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s (%s): expected %h actual %h",
                                      name, op.name(), expected, actual));
        end
    endtask

    task automatic verify_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_with_error($sformatf("mismatch %s latency: expected %0d edges actual %0d edges",
                                      name, expected, actual));
        end
    endtask

    task automatic expect_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s: expected %b actual %b",
                                      name, expected, actual));
        end
    endtask

    // RISC-V M-extension rules, worked out in 64-bit arithmetic
    function automatic logic [XLEN-1:0] expected_result(input muldiv_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (op)
            OP_MUL: begin
                prod = ua * ub;
                return prod[31:0];
            end
            OP_MULH: begin
                prod = sa * sb;
                return prod[63:32];
            end
            OP_MULHSU: begin
                prod = sa * ub; // product modulo 2^64 is exact for a signed times unsigned pair
                return prod[63:32];
            end
            OP_MULHU: begin
                prod = ua * ub;
                return prod[63:32];
            end
            OP_DIV: begin
                if (b == '0) return '1;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a; // overflow case
                sq = sa / sb;
                return sq[31:0];
            end
            OP_DIVU: begin
                if (b == '0) return '1;
                prod = ua / ub;
                return prod[31:0];
            end
            OP_REM: begin
                if (b == '0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return '0;
                sq = sa % sb; // truncating, so the sign follows the dividend
                return sq[31:0];
            end
            default: begin
                if (b == '0) return a;
                prod = ua % ub;
                return prod[31:0];
            end
        endcase
    endfunction

    task automatic add_row(input string name, input muldiv_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
        row_name.push_back(name);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_exp.push_back(exp);
    endtask

    task automatic load_table();
        add_row("mul_pos",          OP_MUL,    32'h0000_0007, 32'h0000_0006, 32'h0000_002a);
        add_row("mul_neg",          OP_MUL,    32'hffff_ffff, 32'h0000_0005, 32'hffff_fffb);
        add_row("mul_wrap",         OP_MUL,    32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
        add_row("mulh_pos",         OP_MULH,   32'h4000_0000, 32'h0000_0004, 32'h0000_0001);
        add_row("mulh_neg_neg",     OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
        add_row("mulh_mixed",       OP_MULH,   32'hffff_fffe, 32'h0000_0003, 32'hffff_ffff);
        add_row("mulh_minneg",      OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_row("mulh_minneg_one",  OP_MULH,   32'h8000_0000, 32'h0000_0001, 32'hffff_ffff);
        add_row("mulhsu_neg",       OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        add_row("mulhsu_pos",       OP_MULHSU, 32'h0000_0002, 32'h8000_0000, 32'h0000_0001);
        add_row("mulhsu_minneg",    OP_MULHSU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_row("mulhu_max",        OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_row("mulhu_minneg",     OP_MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
        add_row("div_pos",          OP_DIV,    32'h0000_0014, 32'h0000_0003, 32'h0000_0006);
        add_row("div_neg_dividend", OP_DIV,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa);
        add_row("div_neg_divisor",  OP_DIV,    32'h0000_0014, 32'hffff_fffd, 32'hffff_fffa);
        add_row("divu_large",       OP_DIVU,   32'hffff_ffff, 32'h0000_0002, 32'h7fff_ffff);
        add_row("rem_neg_dividend", OP_REM,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffe);
        add_row("rem_neg_divisor",  OP_REM,    32'h0000_0014, 32'hffff_fffd, 32'h0000_0002);
        add_row("remu_pos",         OP_REMU,   32'h0000_0064, 32'h0000_0007, 32'h0000_0002);
        add_row("div_by_zero",      OP_DIV,    32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_row("divu_by_zero",     OP_DIVU,   32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
        add_row("rem_by_zero",      OP_REM,    32'h8765_4321, 32'h0000_0000, 32'h8765_4321);
        add_row("remu_by_zero",     OP_REMU,   32'h8765_4321, 32'h0000_0000, 32'h8765_4321);
        add_row("div_overflow",     OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        add_row("rem_overflow",     OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
        add_row("divu_minneg",      OP_DIVU,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
    endtask

    // random operands lean on the corner values now and then
    function automatic logic [XLEN-1:0] pick_operand();
        int unsigned sel;
        sel = $urandom_range(9, 0);
        case (sel)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0001;
            default: return $urandom();
        endcase
    endfunction

    task automatic pulse_start(input muldiv_op_e op, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b);
        @(posedge clk);
        #DRIVE_DELAY;
        start  = 1'b1;
        funct3 = op;
        rs1    = a;
        rs2    = b;
        @(posedge clk); // this edge samples start
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    // called right after pulse_start, so the first edge is already counted
    task automatic wait_for_done(input string name, output int edges);
        edges = 1;
        @(negedge clk);
        while (!done) begin
            expect_flag({name, " busy"}, 1'b1, busy);
            if (edges > EDGE_LIMIT) begin
                stop_with_error($sformatf("%s: done did not arrive within %0d edges",
                                          name, EDGE_LIMIT));
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        expect_flag({name, " busy at done"}, 1'b0, busy);
    endtask

    task automatic run_row(input string name, input muldiv_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] exp);
        int              edges;
        logic [XLEN-1:0] value;
        pulse_start(op, a, b);
        wait_for_done(name, edges);
        value = result;
        compare_result(name, op, exp, value);
        verify_latency(name, LATENCY_EDGES, edges);
        @(negedge clk);
        expect_flag({name, " done width"}, 1'b0, done);
        compare_result({name, " held"}, op, exp, result);
    endtask

    // the second start lands mid-run and must leave no trace
    task automatic apply_ignored_start();
        int edges;
        pulse_start(OP_DIVU, 32'd1000, 32'd7);
        repeat (4) @(posedge clk);
        pulse_start(OP_MUL, 32'd3, 32'd5);
        wait_for_done("ignored_start", edges);
        compare_result("ignored_start", OP_DIVU, 32'd142, result);
        // the ignored start was sampled six edges after the first one
        verify_latency("ignored_start", LATENCY_EDGES - 6, edges);
        repeat (45) begin
            @(negedge clk);
            expect_flag("ignored_start second done", 1'b0, done);
            expect_flag("ignored_start busy after done", 1'b0, busy);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("timeout: the run took longer than the watchdog allows");
    end

    initial begin
        muldiv_op_e      op;
        logic [2:0]      code;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        clk    = 1'b0;
        reset  = 1'b1;
        start  = 1'b0;
        funct3 = 3'b000;
        rs1    = '0;
        rs2    = '0;
        void'($urandom(41));
        load_table();
        if (row_name.size() != NUM_ROWS) begin
            stop_with_error("the stimulus table does not hold the expected number of rows");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        expect_flag("after_reset busy", 1'b0, busy);
        expect_flag("after_reset done", 1'b0, done);
        compare_result("after_reset result", OP_MUL, '0, result);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(row_name[i], row_op[i], row_a[i], row_b[i], row_exp[i]);
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            code = 3'($urandom_range(7, 0));
            op   = muldiv_op_e'(code);
            a    = pick_operand();
            b    = pick_operand();
            run_row($sformatf("random_%0d", i), op, a, b, expected_result(op, a, b));
        end

        apply_ignored_start();

        $display("Verification passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/muldiv_req_if.sv
hdl/muldiv_issue.sv
hdl/shift_add_multiplier.sv
hdl/restoring_divider.sv
hdl/div_sign_wrap.sv
hdl/muldiv_result.sv
hdl/muldiv_top.sv
sim/muldiv_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = muldiv_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) hdl/muldiv_settings.svh
PASS_MSG  = Verification passed

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
